// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing
TOP       = reclock_fifo_tb
RTL_TOP   = reclock_fifo_top
FILE_LIST = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
logic/audio_pkg.sv
logic/fifo_pkg.sv
logic/gray_ptr_sync.sv
logic/sample_ram.sv
logic/fifo_write_ctrl.sv
logic/fifo_read_ctrl.sv
logic/fifo_status_monitor.sv
logic/reclock_fifo_top.sv
test/tb_clock_gen.sv
test/reclock_fifo_tb.sv

// File: logic/audio_pkg.sv
// Audio sample definitions
// Channel word width
// Stereo sample pair carried through the reclocking FIFO

package audio_pkg;

    // ==================================================
    // Sample format
    // ==================================================

    localparam int sample_width = 32;  // Bits per channel word

    // One stereo frame, left in the upper half
    typedef struct packed {
        logic [sample_width-1:0] left;   // Left channel
        logic [sample_width-1:0] right;  // Right channel
    } stereo_sample_t;

endpackage

// File: logic/fifo_pkg.sv
// Reclocking FIFO definitions
// Depth, pointer width, prefill and watermark constants
// Pointer and fill count types, FIFO status flags

package fifo_pkg;

    // ==================================================
    // Geometry
    // ==================================================

    localparam int fifo_depth = 16;                  // Entries
    localparam int ptr_width  = $clog2(fifo_depth);  // Address bits

    // Reader holds back this many samples
    localparam int prefill_level = 4;

    // Watermarks for the health flags
    localparam int low_mark  = 2;   // Below this, nearly empty
    localparam int high_mark = 12;  // Above this, nearly full

    // ==================================================
    // Types
    // ==================================================

    typedef logic [ptr_width:0] ptr_t;   // Address plus wrap bit
    typedef logic [ptr_width:0] fill_t;  // 0 .. fifo_depth

    typedef struct packed {
        logic nearly_empty;
        logic healthy;
        logic nearly_full;
    } fifo_status_t;

endpackage

// File: logic/fifo_read_ctrl.sv
// Read side control, clk_read domain
// Fill count from synchronized write pointer
// Prefill hold-back, one sample per cycle once above it
// Registered output sample and valid strobe

`timescale 1ns/1ps

module fifo_read_ctrl
    import audio_pkg::*;
    import fifo_pkg::*;
(
    input  logic           clk_read,
    input  logic           rst_n,
    input  ptr_t           wr_ptr_sync,  // Write pointer seen from this domain
    input  stereo_sample_t rd_data,      // Memory word at rd_ptr
    output ptr_t           rd_ptr,       // Binary read pointer with wrap bit
    output fill_t          fill,         // Entries available to the reader
    output stereo_sample_t out_sample,
    output logic           out_valid
);

    logic rd_go;  // Read decision this cycle

    // ==================================================
    // Fill count and read decision
    // ==================================================

    // Modulo subtraction, wrap bit keeps full and empty apart
    assign fill = wr_ptr_sync - rd_ptr;

    // Keep prefill_level frames in reserve
    assign rd_go = (fill > fill_t'(prefill_level));

    // ==================================================
    // Pointer and strobe
    // ==================================================

    always_ff @(posedge clk_read or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_go;  // Valid one cycle after decision
            if (rd_go) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
        end
    end

    // ==================================================
    // Output sample
    // ==================================================

    // Payload only, qualified by out_valid
    always_ff @(posedge clk_read) begin
        if (rd_go) begin
            out_sample <= rd_data;
        end
    end

endmodule

// File: logic/fifo_status_monitor.sv
// FIFO fill report, clk_read domain
// Registered fill level
// Nearly empty, healthy and nearly full flags from the watermarks

`timescale 1ns/1ps

module fifo_status_monitor
    import fifo_pkg::*;
(
    input  logic         clk_read,
    input  logic         rst_n,
    input  fill_t        fill,        // Live count from the reader
    output fill_t        fill_level,  // One cycle behind fill
    output fifo_status_t status
);

    fifo_status_t status_next;

    // Watermark rule, exactly one flag set
    always_comb begin
        status_next.nearly_empty = (fill < fill_t'(low_mark));
        status_next.nearly_full  = (fill > fill_t'(high_mark));
        status_next.healthy      = !status_next.nearly_empty && !status_next.nearly_full;
    end

    // Level and flags update together
    always_ff @(posedge clk_read or negedge rst_n) begin
        if (!rst_n) begin
            fill_level <= '0;
            status     <= '{nearly_empty: 1'b1, healthy: 1'b0, nearly_full: 1'b0};
        end else begin
            fill_level <= fill;
            status     <= status_next;
        end
    end

endmodule

// File: logic/fifo_write_ctrl.sv
// Write side control, clk_write domain
// Full detection against the synchronized read pointer
// Write enable and write pointer advance

`timescale 1ns/1ps

module fifo_write_ctrl
    import fifo_pkg::*;
(
    input  logic clk_write,
    input  logic rst_n,
    input  logic in_valid,     // One-cycle sample strobe
    input  ptr_t rd_ptr_sync,  // Read pointer seen from this domain
    output logic wr_en,        // Store in_sample this cycle
    output ptr_t wr_ptr        // Binary write pointer with wrap bit
);

    logic addr_match;  // Same slot
    logic wrap_diff;   // Writer one lap ahead
    logic full;

    // ==================================================
    // Full flag
    // ==================================================

    // Pessimistic, since rd_ptr_sync lags the real reader
    assign addr_match = (wr_ptr[ptr_width-1:0] == rd_ptr_sync[ptr_width-1:0]);
    assign wrap_diff  = (wr_ptr[ptr_width] != rd_ptr_sync[ptr_width]);
    assign full       = addr_match && wrap_diff;

    // Strobe while full is lost, no back-pressure
    assign wr_en = in_valid && !full;

    // ==================================================
    // Write pointer
    // ==================================================

    always_ff @(posedge clk_write or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + ptr_t'(1);  // Wraps through the extra bit
        end
    end

endmodule

// File: logic/gray_ptr_sync.sv
// Pointer crossing between clock domains
// Gray encode register in the source domain
// Two-flop synchronizer in the destination domain, decoded back to binary

`timescale 1ns/1ps

module gray_ptr_sync
    import fifo_pkg::*;
(
    input  logic src_clk,  // Source domain clock
    input  logic clk,      // Destination domain clock
    input  logic rst_n,
    input  ptr_t src_ptr,  // Binary pointer, source domain
    output ptr_t dst_ptr   // Binary pointer, destination domain
);

    ptr_t src_gray;   // Glitch-free launch register
    ptr_t meta_gray;  // First stage, may go metastable
    ptr_t sync_gray;  // Second stage, safe to use

    // Gray back to binary, MSB first
    function automatic ptr_t gray_to_bin(input ptr_t g);
        ptr_t b;
        b[ptr_width] = g[ptr_width];
        for (int i = ptr_width - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // Only one bit changes per increment
    always_ff @(posedge src_clk or negedge rst_n) begin
        if (!rst_n) begin
            src_gray <= '0;
        end else begin
            src_gray <= src_ptr ^ (src_ptr >> 1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta_gray <= '0;
            sync_gray <= '0;
        end else begin
            meta_gray <= src_gray;
            sync_gray <= meta_gray;
        end
    end

    assign dst_ptr = gray_to_bin(sync_gray);

endmodule

// File: logic/reclock_fifo_top.sv
// Audio reclocking FIFO, top level
// Write control and sample memory on clk_write
// Gray pointer synchronizers in both directions
// Read control and status monitor on clk_read

`timescale 1ns/1ps

module reclock_fifo_top
    import audio_pkg::*;
    import fifo_pkg::*;
(
    input  logic           clk_write,   // Incoming sample clock
    input  logic           clk_read,    // Local output clock
    input  logic           rst_n,
    input  stereo_sample_t in_sample,
    input  logic           in_valid,
    output stereo_sample_t out_sample,
    output logic           out_valid,
    output fill_t          fill_level,
    output fifo_status_t   status
);

    logic           wr_en;
    ptr_t           wr_ptr;
    ptr_t           rd_ptr;
    ptr_t           wr_ptr_sync;  // Write pointer in clk_read domain
    ptr_t           rd_ptr_sync;  // Read pointer in clk_write domain
    stereo_sample_t rd_data;
    fill_t          fill;

    // ==================================================
    // Write side
    // ==================================================

    fifo_write_ctrl wr_ctrl_i (
        .clk_write   (clk_write),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .rd_ptr_sync (rd_ptr_sync),
        .wr_en       (wr_en),
        .wr_ptr      (wr_ptr)
    );

    sample_ram ram_i (
        .clk_write (clk_write),
        .wr_en     (wr_en),
        .wr_addr   (wr_ptr[ptr_width-1:0]),  // Drop wrap bit
        .wr_data   (in_sample),
        .rd_addr   (rd_ptr[ptr_width-1:0]),
        .rd_data   (rd_data)
    );

    // ==================================================
    // Pointer crossing
    // ==================================================

    gray_ptr_sync wr_sync_i (
        .src_clk (clk_write),
        .clk     (clk_read),
        .rst_n   (rst_n),
        .src_ptr (wr_ptr),
        .dst_ptr (wr_ptr_sync)
    );

    gray_ptr_sync rd_sync_i (
        .src_clk (clk_read),
        .clk     (clk_write),
        .rst_n   (rst_n),
        .src_ptr (rd_ptr),
        .dst_ptr (rd_ptr_sync)
    );

    // ==================================================
    // Read side and status
    // ==================================================

    fifo_read_ctrl rd_ctrl_i (
        .clk_read    (clk_read),
        .rst_n       (rst_n),
        .wr_ptr_sync (wr_ptr_sync),
        .rd_data     (rd_data),
        .rd_ptr      (rd_ptr),
        .fill        (fill),
        .out_sample  (out_sample),
        .out_valid   (out_valid)
    );

    fifo_status_monitor status_i (
        .clk_read   (clk_read),
        .rst_n      (rst_n),
        .fill       (fill),
        .fill_level (fill_level),
        .status     (status)
    );

endmodule

// File: logic/sample_ram.sv
// Dual-clock sample memory
// Synchronous write on the write clock
// Asynchronous read, sampled by the reader on its own clock

`timescale 1ns/1ps

module sample_ram
    import audio_pkg::*;
    import fifo_pkg::*;
(
    input  logic                 clk_write,
    input  logic                 wr_en,
    input  logic [ptr_width-1:0] wr_addr,
    input  stereo_sample_t       wr_data,
    input  logic [ptr_width-1:0] rd_addr,
    output stereo_sample_t       rd_data
);

    stereo_sample_t mem [0:fifo_depth-1];  // Stereo frames

    always_ff @(posedge clk_write) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Reader registers this in fifo_read_ctrl
    assign rd_data = mem[rd_addr];

endmodule

// File: test/reclock_fifo_tb.sv
// Testbench for the audio reclocking FIFO
// Vector playback on clk_write, expected sample queue
// Output order and data, settled fill level, watermark flags
// Cycle limit derived from the vector count

`timescale 1ns/1ps

module reclock_fifo_tb
    import audio_pkg::*;
    import fifo_pkg::*;
();

    logic           clk_read;
    logic           clk_write;
    logic           rst_n;
    stereo_sample_t in_sample;
    logic           in_valid;
    stereo_sample_t out_sample;
    logic           out_valid;
    fill_t          fill_level;
    fifo_status_t   status;

    logic [67:0]    vec_mem [0:63];  // Tag nibble plus 64 data bits
    logic [3:0]     tag;
    logic [63:0]    data;
    stereo_sample_t expected_q [$];  // Written, not yet seen at the output
    int idx;
    int n_entries;
    int cur_test;
    int tests_run;
    int written;      // Accepted writes so far
    int out_count;    // Samples seen at the output
    int settled;
    int check_count;
    int err_count;
    int test_errs;
    int cycle_count;
    int cycle_limit;
    bit done;

    tb_clock_gen clk_gen_i (
        .clk_read  (clk_read),
        .clk_write (clk_write),
        .rst_n     (rst_n)
    );

    reclock_fifo_top dut_i (
        .clk_write  (clk_write),
        .clk_read   (clk_read),
        .rst_n      (rst_n),
        .in_sample  (in_sample),
        .in_valid   (in_valid),
        .out_sample (out_sample),
        .out_valid  (out_valid),
        .fill_level (fill_level),
        .status     (status)
    );

    // Watermark rule, one flag per level band
    function automatic fifo_status_t watermark_flags(input fill_t lvl);
        fifo_status_t f;
        f = '0;
        if (lvl < fill_t'(low_mark)) begin
            f.nearly_empty = 1'b1;  // Below the low watermark
        end else if (lvl > fill_t'(high_mark)) begin
            f.nearly_full = 1'b1;   // Above the high watermark
        end else begin
            f.healthy = 1'b1;
        end
        return f;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic report_test();
        if (cur_test != 0) begin
            $display("Test %0d finished with %0d errors", cur_test, test_errs);
            tests_run++;
        end
    endtask

    // ==================================================
    // Output side, sampled mid-cycle
    // ==================================================

    always @(negedge clk_read) begin
        if (rst_n) begin
            check_value(64'(status), 64'(watermark_flags(fill_level)), "status flags");
            check_value(64'(fill_level > fill_t'(fifo_depth)), 64'd0, "fill_level above depth");
            if (out_valid) begin
                if (expected_q.size() == 0) begin
                    $display("Output strobe at %0t ns with no sample left to expect", $time);
                    err_count++;
                    test_errs++;
                end else begin
                    check_value(out_sample, expected_q.pop_front(), "out_sample");
                    out_count++;
                end
            end
        end
    end

    // ==================================================
    // Run limit
    // ==================================================

    always @(posedge clk_read) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_limit != 0 && cycle_count >= cycle_limit);
        $display("Timeout: run did not finish within %0d clk_read cycles", cycle_limit);
        $display("*** FAILED ***");
        $finish;
    end

    // ==================================================
    // Vector playback
    // ==================================================

    initial begin
        in_sample   = '0;
        in_valid    = 1'b0;
        cycle_count = 0;
        cycle_limit = 0;
        $readmemh("test/reclock_vectors.txt", vec_mem);
        n_entries = 64;
        for (int i = 0; i < 64; i++) begin
            if (vec_mem[i][67:64] == 4'h0 && n_entries == 64) begin
                n_entries = i + 1;  // Up to and with the end tag
            end
        end
        cycle_limit = 40 * n_entries + 200;
        wait (rst_n);
        idx = 0;
        while (!done && idx < 64) begin
            tag  = vec_mem[idx][67:64];
            data = vec_mem[idx][63:0];
            case (tag)
                4'h1: begin  // New test
                    report_test();
                    cur_test  = int'(data);
                    test_errs = 0;
                end
                4'h2: begin  // One strobe per sample
                    @(posedge clk_write);
                    in_sample <= stereo_sample_t'(data);
                    in_valid  <= 1'b1;
                    expected_q.push_back(stereo_sample_t'(data));
                    written++;
                end
                4'h3: begin  // Idle gap, then settled checks
                    @(posedge clk_write);
                    in_valid <= 1'b0;
                    repeat (int'(data)) @(posedge clk_write);
                    @(negedge clk_read);
                    if (data >= 64'd30) begin
                        settled = (written > prefill_level) ? prefill_level : written;
                        check_value(64'(fill_level), 64'(settled), "settled fill_level");
                        check_value(64'(out_count), 64'(written - settled), "output count");
                    end
                end
                default: done = 1'b1;
            endcase
            idx++;
        end
        in_valid <= 1'b0;
        report_test();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, check_count, err_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: test/reclock_vectors.txt
// Columns: tag digit, then 16 hex digits of data (left word, right word)
// Tags: 1 test marker, 2 sample, 3 idle gap in clk_write cycles, 0 end
10000000000000001
3000000000000001E
10000000000000002
2A00000015F000001
2A00000025F000002
2A00000035F000003
2A00000045F000004
3000000000000001E
10000000000000003
2B00000106E000010
2B00000116E000011
2B00000126E000012
2B00000136E000013
2B00000146E000014
2B00000156E000015
2B00000166E000016
2B00000176E000017
2B00000186E000018
2B00000196E000019
30000000000000028
10000000000000004
2C00000207D000020
2C00000217D000021
2C00000227D000022
2C00000237D000023
2C00000247D000024
2C00000257D000025
30000000000000028
00000000000000000

// File: test/tb_clock_gen.sv
// Testbench clocks and reset
// clk_read at 10 ns, clk_write at 14 ns
// rst_n held low for 10 clk_read cycles

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_read,
    output logic clk_write,
    output logic rst_n
);

    initial begin
        clk_read  = 1'b0;
        clk_write = 1'b0;
        rst_n     = 1'b0;
    end

    always #5 clk_read = ~clk_read;    // 100 MHz local clock
    always #7 clk_write = ~clk_write;  // Slower incoming clock

    // Release away from the read edge
    initial begin
        repeat (10) @(posedge clk_read);
        @(negedge clk_read);
        rst_n <= 1'b1;
    end

endmodule
